// ==== logic/soc_map_pkg.sv ====
// address map of the copy engine, referenced by scoped name from the memory bank and the DMA
package soc_map_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // address type
   ////////////////////////////////////////////////////////////////////////////

   localparam int ADDR_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;  // byte address

   ////////////////////////////////////////////////////////////////////////////
   // region map
   ////////////////////////////////////////////////////////////////////////////

   // both regions share one mask, so the top three bits pick the region
   localparam addr_t REGION_MASK = 32'hE000_0000;

   localparam addr_t ROM_BASE = 32'h0000_0000;  // boot image
   localparam addr_t RAM_BASE = 32'h2000_0000;  // working memory

   // decoded target of one access
   typedef enum logic [1:0] {
      REG_ROM,
      REG_RAM,
      REG_NONE   // nothing answers here
   } region_e;

endpackage

// ==== logic/dma_pkg.sv ====
// transfer types of the copy engine, referenced by scoped name from the datapath modules
package dma_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // payload
   ////////////////////////////////////////////////////////////////////////////

   localparam int DATA_W = 32;

   typedef logic [DATA_W-1:0] word_t;  // one beat of payload

   ////////////////////////////////////////////////////////////////////////////
   // transfer length and stride
   ////////////////////////////////////////////////////////////////////////////

   localparam int LEN_W = 10;

   // counts words, legal range 1 to 512
   typedef logic [LEN_W-1:0] len_t;

   // bytes the address moves per word
   localparam int unsigned WORD_BYTES = DATA_W / 8;

endpackage

// ==== logic/beat_if.sv ====
// one payload beat under a four-phase req/ack handshake between two datapath stages
interface beat_if;

   logic          req;   // payload valid and stable while high
   logic          ack;   // payload taken
   dma_pkg::word_t data;
   logic          last;  // final beat of the transfer
   logic          err;   // source read hit an unmapped address

   // side that offers beats
   modport producer (
      output req,
      output data,
      output last,
      output err,
      input  ack
   );

   // side that takes beats
   modport consumer (
      input  req,
      input  data,
      input  last,
      input  err,
      output ack
   );

endinterface

// ==== logic/mem_bank.sv ====
// rom and ram arrays behind the address decoder, with dma read, dma write and host ports
module mem_bank #(
   parameter int unsigned MEM_WORDS = 512
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  soc_map_pkg::addr_t  rd_addr_i,
   output dma_pkg::word_t      rd_data_o,
   output logic                rd_err_o,
   input  logic                wr_en_i,
   input  soc_map_pkg::addr_t  wr_addr_i,
   input  dma_pkg::word_t      wr_data_i,
   output logic                wr_err_o,
   input  logic                host_we_i,
   input  soc_map_pkg::addr_t  host_addr_i,
   input  dma_pkg::word_t      host_wdata_i,
   output dma_pkg::word_t      host_rdata_o
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   dma_pkg::word_t rom [MEM_WORDS];
   dma_pkg::word_t ram [MEM_WORDS];

   soc_map_pkg::region_e rd_region, wr_region, host_region;
   logic [IDX_W-1:0]     rd_idx, wr_idx, host_idx;

   // base and mask compare, same rule for every port
   function automatic soc_map_pkg::region_e decode(input soc_map_pkg::addr_t addr);
      soc_map_pkg::addr_t masked;
      masked = addr & soc_map_pkg::REGION_MASK;
      if (masked == soc_map_pkg::ROM_BASE) begin
         return soc_map_pkg::REG_ROM;
      end else if (masked == soc_map_pkg::RAM_BASE) begin
         return soc_map_pkg::REG_RAM;
      end
      return soc_map_pkg::REG_NONE;
   endfunction

   assign rd_region   = decode(rd_addr_i);
   assign wr_region   = decode(wr_addr_i);
   assign host_region = decode(host_addr_i);

   // word index wraps inside the region
   assign rd_idx   = rd_addr_i[2 +: IDX_W];
   assign wr_idx   = wr_addr_i[2 +: IDX_W];
   assign host_idx = host_addr_i[2 +: IDX_W];

   ////////////////////////////////////////////////////////////////////////////
   // combinational reads
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (rd_region)
         soc_map_pkg::REG_ROM: rd_data_o = rom[rd_idx];
         soc_map_pkg::REG_RAM: rd_data_o = ram[rd_idx];
         default:              rd_data_o = '0;
      endcase
      case (host_region)
         soc_map_pkg::REG_ROM: host_rdata_o = rom[host_idx];
         soc_map_pkg::REG_RAM: host_rdata_o = ram[host_idx];
         default:              host_rdata_o = '0;
      endcase
   end

   assign rd_err_o = (rd_region == soc_map_pkg::REG_NONE);
   assign wr_err_o = wr_en_i && (wr_region != soc_map_pkg::REG_RAM);  // rom is host only

   ////////////////////////////////////////////////////////////////////////////
   // clocked writes
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_n_i) begin  // arrays stay untouched during reset
         if (wr_en_i && wr_region == soc_map_pkg::REG_RAM) begin
            ram[wr_idx] <= wr_data_i;
         end
         if (host_we_i) begin
            case (host_region)
               soc_map_pkg::REG_ROM: rom[host_idx] <= host_wdata_i;
               soc_map_pkg::REG_RAM: ram[host_idx] <= host_wdata_i;
               default: ;  // unmapped host write is ignored
            endcase
         end
      end
   end

endmodule

// ==== logic/dma_reader.sv ====
// source side of the copy channel, reads each word and offers it as a beat
module dma_reader (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                start_i,
   input  soc_map_pkg::addr_t  src_addr_i,
   input  dma_pkg::len_t       len_i,
   output soc_map_pkg::addr_t  rd_addr_o,
   input  dma_pkg::word_t      rd_data_i,
   input  logic                rd_err_i,
   beat_if.producer            beat_o
);

   typedef enum logic [1:0] {
      s_idle,
      s_load,   // sample memory, raise req
      s_req,    // hold payload until ack
      s_drop    // req low, wait for ack to fall
   } state_t;

   state_t             state_q;
   soc_map_pkg::addr_t addr_q;
   dma_pkg::len_t      remain_q;   // words not yet handed over
   logic               req_q;
   dma_pkg::word_t     data_q;
   logic               last_q, err_q;

   assign rd_addr_o   = addr_q;
   assign beat_o.req  = req_q;
   assign beat_o.data = data_q;
   assign beat_o.last = last_q;
   assign beat_o.err  = err_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= s_idle;
         addr_q   <= '0;
         remain_q <= '0;
         req_q    <= 1'b0;
      end else begin
         case (state_q)
            s_idle: begin
               if (start_i) begin
                  addr_q   <= src_addr_i;
                  remain_q <= len_i;
                  state_q  <= s_load;
               end
            end
            s_load: begin
               req_q   <= 1'b1;
               state_q <= s_req;
            end
            s_req: begin
               if (beat_o.ack) begin
                  req_q    <= 1'b0;
                  addr_q   <= addr_q + soc_map_pkg::addr_t'(dma_pkg::WORD_BYTES);
                  remain_q <= remain_q - dma_pkg::len_t'(1);
                  state_q  <= s_drop;
               end
            end
            default: begin
               if (!beat_o.ack) begin  // handshake closed
                  state_q <= (remain_q == '0) ? s_idle : s_load;
               end
            end
         endcase
      end
   end

   // payload, held stable from load until the next load
   always_ff @(posedge clk_i) begin
      if (state_q == s_load) begin
         data_q <= rd_data_i;
         err_q  <= rd_err_i;
         last_q <= (remain_q == dma_pkg::len_t'(1));
      end
   end

endmodule

// ==== logic/word_fifo.sv ====
// circular beat buffer between reader and writer, one handshake on each side
module word_fifo #(
   parameter int unsigned FIFO_DEPTH = 4
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   beat_if.consumer in_i,
   beat_if.producer out_o
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   dma_pkg::word_t data_mem [FIFO_DEPTH];
   logic           last_mem [FIFO_DEPTH];
   logic           err_mem  [FIFO_DEPTH];

   logic [PTR_W:0] wr_ptr_q, rd_ptr_q;   // extra bit tells full from empty
   logic           empty, full;
   logic           push, pop;
   logic           in_ack_q;
   logic           out_req_q;
   logic           out_pend_q;   // head entry offered, not yet popped

   assign empty = (wr_ptr_q == rd_ptr_q);
   assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                  (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

   assign push = in_i.req && !in_ack_q && !full;
   assign pop  = out_pend_q && !out_req_q && !out_o.ack;  // ack has fallen

   assign in_i.ack    = in_ack_q;
   assign out_o.req   = out_req_q;
   assign out_o.data  = data_mem[rd_ptr_q[PTR_W-1:0]];
   assign out_o.last  = last_mem[rd_ptr_q[PTR_W-1:0]];
   assign out_o.err   = err_mem[rd_ptr_q[PTR_W-1:0]];

   ////////////////////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (push) begin
         data_mem[wr_ptr_q[PTR_W-1:0]] <= in_i.data;
         last_mem[wr_ptr_q[PTR_W-1:0]] <= in_i.last;
         err_mem[wr_ptr_q[PTR_W-1:0]]  <= in_i.err;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // handshakes and pointers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         in_ack_q   <= 1'b0;
         out_req_q  <= 1'b0;
         out_pend_q <= 1'b0;
      end else begin
         // upstream side
         if (push) begin
            wr_ptr_q <= wr_ptr_q + (PTR_W+1)'(1);
            in_ack_q <= 1'b1;
         end else if (in_ack_q && !in_i.req) begin
            in_ack_q <= 1'b0;
         end

         // downstream side
         if (!out_pend_q && !empty && !out_o.ack) begin
            out_req_q  <= 1'b1;
            out_pend_q <= 1'b1;
         end else if (out_req_q && out_o.ack) begin
            out_req_q <= 1'b0;
         end else if (pop) begin
            rd_ptr_q   <= rd_ptr_q + (PTR_W+1)'(1);
            out_pend_q <= 1'b0;
         end
      end
   end

endmodule

// ==== logic/dma_writer.sv ====
// destination side of the copy channel, writes beats out and reports busy, done and error
module dma_writer (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                start_i,
   input  soc_map_pkg::addr_t  dst_addr_i,
   beat_if.consumer            beat_i,
   output logic                wr_en_o,
   output soc_map_pkg::addr_t  wr_addr_o,
   output dma_pkg::word_t      wr_data_o,
   input  logic                wr_err_i,
   output logic                busy_o,
   output logic                done_o,
   output logic                err_o
);

   soc_map_pkg::addr_t addr_q;
   logic               ack_q;
   logic               busy_q;
   logic               done_q;
   logic               err_q;   // sticky until next start

   // write straight out of the beat, no staging register
   assign wr_en_o   = busy_q && beat_i.req && !ack_q;
   assign wr_addr_o = addr_q;
   assign wr_data_o = beat_i.data;

   assign beat_i.ack = ack_q;
   assign busy_o     = busy_q;
   assign done_o     = done_q;
   assign err_o      = err_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         addr_q <= '0;
         ack_q  <= 1'b0;
         busy_q <= 1'b0;
         done_q <= 1'b0;
         err_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;  // single cycle pulse

         if (start_i) begin
            addr_q <= dst_addr_i;
            busy_q <= 1'b1;
            err_q  <= 1'b0;
         end else if (wr_en_o) begin
            addr_q <= addr_q + soc_map_pkg::addr_t'(dma_pkg::WORD_BYTES);
            err_q  <= err_q | beat_i.err | wr_err_i;
            if (beat_i.last) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end

         // ack follows the write, falls once req is gone
         if (wr_en_o) begin
            ack_q <= 1'b1;
         end else if (ack_q && !beat_i.req) begin
            ack_q <= 1'b0;
         end
      end
   end

endmodule

// ==== logic/dma_soc_top.sv ====
// top of the copy engine, ties memory bank, reader, fifo and writer to plain ports
module dma_soc_top #(
   parameter int unsigned FIFO_DEPTH = 4,
   parameter int unsigned MEM_WORDS  = 512
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                start_i,
   input  soc_map_pkg::addr_t  src_addr_i,
   input  soc_map_pkg::addr_t  dst_addr_i,
   input  dma_pkg::len_t       len_i,
   output logic                busy_o,
   output logic                done_o,
   output logic                err_o,
   input  logic                host_we_i,
   input  soc_map_pkg::addr_t  host_addr_i,
   input  dma_pkg::word_t      host_wdata_i,
   output dma_pkg::word_t      host_rdata_o
);

   soc_map_pkg::addr_t rd_addr, wr_addr;
   dma_pkg::word_t     rd_data, wr_data;
   logic               rd_err, wr_err, wr_en;

   beat_if reader_to_fifo ();
   beat_if fifo_to_writer ();

   ////////////////////////////////////////////////////////////////////////////
   // memory
   ////////////////////////////////////////////////////////////////////////////

   mem_bank #(
      .MEM_WORDS    ( MEM_WORDS    )
   ) u_mem_bank (
      .clk_i        ( clk_i        ),
      .rst_n_i      ( rst_n_i      ),
      .rd_addr_i    ( rd_addr      ),
      .rd_data_o    ( rd_data      ),
      .rd_err_o     ( rd_err       ),
      .wr_en_i      ( wr_en        ),
      .wr_addr_i    ( wr_addr      ),
      .wr_data_i    ( wr_data      ),
      .wr_err_o     ( wr_err       ),
      .host_we_i    ( host_we_i    ),
      .host_addr_i  ( host_addr_i  ),
      .host_wdata_i ( host_wdata_i ),
      .host_rdata_o ( host_rdata_o )
   );

   ////////////////////////////////////////////////////////////////////////////
   // copy channel
   ////////////////////////////////////////////////////////////////////////////

   dma_reader u_dma_reader (
      .clk_i      ( clk_i          ),
      .rst_n_i    ( rst_n_i        ),
      .start_i    ( start_i        ),
      .src_addr_i ( src_addr_i     ),
      .len_i      ( len_i          ),
      .rd_addr_o  ( rd_addr        ),
      .rd_data_i  ( rd_data        ),
      .rd_err_i   ( rd_err         ),
      .beat_o     ( reader_to_fifo )
   );

   word_fifo #(
      .FIFO_DEPTH ( FIFO_DEPTH     )
   ) u_word_fifo (
      .clk_i      ( clk_i          ),
      .rst_n_i    ( rst_n_i        ),
      .in_i       ( reader_to_fifo ),
      .out_o      ( fifo_to_writer )
   );

   dma_writer u_dma_writer (
      .clk_i      ( clk_i          ),
      .rst_n_i    ( rst_n_i        ),
      .start_i    ( start_i        ),
      .dst_addr_i ( dst_addr_i     ),
      .beat_i     ( fifo_to_writer ),
      .wr_en_o    ( wr_en          ),
      .wr_addr_o  ( wr_addr        ),
      .wr_data_o  ( wr_data        ),
      .wr_err_i   ( wr_err         ),
      .busy_o     ( busy_o         ),
      .done_o     ( done_o         ),
      .err_o      ( err_o          )
   );

endmodule

// ==== testbench/tb_dma_soc.sv ====
// testbench for the copy engine, loads both memories, runs copies and checks them against a model
module tb_dma_soc;

   localparam int unsigned FIFO_DEPTH = 4;
   localparam int unsigned MEM_WORDS  = 512;

   // roughly 300 words at about 8 cycles each, plus margin
   localparam int WORDS_EST       = 300;
   localparam int CYCLES_PER_WORD = 8;
   localparam int MAX_CYCLES      = WORDS_EST * CYCLES_PER_WORD + 600;

   logic               clk = 1'b0;
   logic               rst_n;
   logic               start;
   soc_map_pkg::addr_t src_addr, dst_addr;
   dma_pkg::len_t      len;
   logic               busy, done, err;
   logic               host_we;
   soc_map_pkg::addr_t host_addr;
   dma_pkg::word_t     host_wdata, host_rdata;

   dma_pkg::word_t     rom_model [MEM_WORDS];
   dma_pkg::word_t     ram_model [MEM_WORDS];

   integer             seed;
   int                 cycle_cnt = 0;
   string              test_name;
   logic               pending = 1'b0;   // copy started, result not yet checked
   logic               exp_err;
   soc_map_pkg::addr_t exp_dst;
   dma_pkg::len_t      exp_len;

   dma_soc_top #(
      .FIFO_DEPTH   ( FIFO_DEPTH ),
      .MEM_WORDS    ( MEM_WORDS  )
   ) u_dma_soc_top (
      .clk_i        ( clk        ),
      .rst_n_i      ( rst_n      ),
      .start_i      ( start      ),
      .src_addr_i   ( src_addr   ),
      .dst_addr_i   ( dst_addr   ),
      .len_i        ( len        ),
      .busy_o       ( busy       ),
      .done_o       ( done       ),
      .err_o        ( err        ),
      .host_we_i    ( host_we    ),
      .host_addr_i  ( host_addr  ),
      .host_wdata_i ( host_wdata ),
      .host_rdata_o ( host_rdata )
   );

   always #50 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic soc_map_pkg::region_e model_region(input soc_map_pkg::addr_t addr);
      if ((addr & soc_map_pkg::REGION_MASK) == soc_map_pkg::ROM_BASE) begin
         return soc_map_pkg::REG_ROM;
      end else if ((addr & soc_map_pkg::REGION_MASK) == soc_map_pkg::RAM_BASE) begin
         return soc_map_pkg::REG_RAM;
      end
      return soc_map_pkg::REG_NONE;
   endfunction

   function automatic int model_idx(input soc_map_pkg::addr_t addr);
      return int'((addr >> 2) % MEM_WORDS);  // word index wraps in the region
   endfunction

   function automatic dma_pkg::word_t model_read(input soc_map_pkg::addr_t addr);
      case (model_region(addr))
         soc_map_pkg::REG_ROM: return rom_model[model_idx(addr)];
         soc_map_pkg::REG_RAM: return ram_model[model_idx(addr)];
         default:              return '0;
      endcase
   endfunction

   // word by word copy, returns the expected error flag
   function automatic logic copy_model(input soc_map_pkg::addr_t src, input soc_map_pkg::addr_t dst,
                                       input dma_pkg::len_t n);
      soc_map_pkg::addr_t s, d;
      logic               bad;
      int                 i;
      bad = 1'b0;
      for (i = 0; i < n; i++) begin
         s = src + soc_map_pkg::addr_t'(i * dma_pkg::WORD_BYTES);
         d = dst + soc_map_pkg::addr_t'(i * dma_pkg::WORD_BYTES);
         if (model_region(s) == soc_map_pkg::REG_NONE) begin
            bad = 1'b1;
         end
         if (model_region(d) == soc_map_pkg::REG_RAM) begin
            ram_model[model_idx(d)] = model_read(s);
         end else begin
            bad = 1'b1;   // rom or unmapped destination is dropped
         end
      end
      return bad;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // compare tasks and host port access
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input dma_pkg::word_t exp,
                             input dma_pkg::word_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s: expected %b, actual %b", name, exp, act);
         $display("*** FAILED ***");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic host_write(input soc_map_pkg::addr_t addr, input dma_pkg::word_t data);
      @(negedge clk);
      host_we    = 1'b1;
      host_addr  = addr;
      host_wdata = data;
      @(negedge clk);
      host_we = 1'b0;
      case (model_region(addr))
         soc_map_pkg::REG_ROM: rom_model[model_idx(addr)] = data;
         soc_map_pkg::REG_RAM: ram_model[model_idx(addr)] = data;
         default: ;
      endcase
   endtask

   task automatic host_read(input soc_map_pkg::addr_t addr, output dma_pkg::word_t data);
      @(negedge clk);
      host_addr = addr;
      @(posedge clk);
      data = host_rdata;   // settled since the falling edge
   endtask

   task automatic run_copy(input string name, input soc_map_pkg::addr_t src,
                           input soc_map_pkg::addr_t dst, input dma_pkg::len_t n);
      test_name = name;
      exp_err   = copy_model(src, dst, n);
      exp_dst   = dst;
      exp_len   = n;
      pending   = 1'b1;
      @(negedge clk);
      start    = 1'b1;
      src_addr = src;
      dst_addr = dst;
      len      = n;
      @(negedge clk);
      start = 1'b0;
      check_flag({name, " busy_o after start"}, 1'b1, busy);
      wait (pending == 1'b0);
      check_flag({name, " busy_o after done"}, 1'b0, busy);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // compare process, runs on every done pulse
   ////////////////////////////////////////////////////////////////////////////

   initial begin : compare_results
      soc_map_pkg::addr_t a;
      dma_pkg::word_t     got;
      int                 i;
      forever begin
         @(negedge clk);
         if (done && !pending) begin
            $display("done_o pulsed while no copy was running");
            $display("*** FAILED ***");
            $fatal(1, "unexpected done");
         end else if (done) begin
            check_flag({test_name, " err_o"}, exp_err, err);
            for (i = 0; i < exp_len; i++) begin
               a = exp_dst + soc_map_pkg::addr_t'(i * dma_pkg::WORD_BYTES);
               host_read(a, got);
               check_word($sformatf("%s @%h", test_name, a), model_read(a), got);
            end
            pending = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $fatal(1, "timeout");
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin : stimulus
      dma_pkg::word_t     got;
      soc_map_pkg::addr_t a;
      int                 i;
      seed       = 32'hed98;
      rst_n      = 1'b0;
      start      = 1'b0;
      src_addr   = '0;
      dst_addr   = '0;
      len        = '0;
      host_we    = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      for (i = 0; i < MEM_WORDS; i++) begin
         rom_model[i] = '0;
         ram_model[i] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("reset busy_o", 1'b0, busy);
      check_flag("reset done_o", 1'b0, done);
      check_flag("reset err_o", 1'b0, err);

      // 16 rom words, 64 ram words
      for (i = 0; i < 16; i++) begin
         host_write(soc_map_pkg::ROM_BASE + soc_map_pkg::addr_t'(4 * i), $random(seed));
      end
      for (i = 0; i < 64; i++) begin
         host_write(soc_map_pkg::RAM_BASE + soc_map_pkg::addr_t'(4 * i), $random(seed));
      end
      for (i = 0; i < 16; i++) begin
         a = soc_map_pkg::ROM_BASE + soc_map_pkg::addr_t'(4 * i);
         host_read(a, got);
         check_word($sformatf("rom readback @%h", a), model_read(a), got);
      end
      for (i = 0; i < 64; i++) begin
         a = soc_map_pkg::RAM_BASE + soc_map_pkg::addr_t'(4 * i);
         host_read(a, got);
         check_word($sformatf("ram readback @%h", a), model_read(a), got);
      end
      host_read(32'h6000_0000, got);
      check_word("unmapped host read", model_read(32'h6000_0000), got);

      run_copy("rom to ram 8", 32'h0000_0000, 32'h2000_0100, 10'd8);
      run_copy("ram to ram 1", 32'h2000_0000, 32'h2000_0200, 10'd1);
      run_copy("ram to ram 40", 32'h2000_0004, 32'h2000_0400, 10'd40);   // longer than the fifo
      run_copy("unmapped source", 32'h6000_0000, 32'h2000_0080, 10'd8);  // over loaded words
      run_copy("rom destination", 32'h2000_0000, 32'h0000_0020, 10'd4);
      run_copy("clean after error", 32'h0000_0000, 32'h2000_0700, 10'd8);

      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== filelist.f ====
logic/soc_map_pkg.sv
logic/dma_pkg.sv
logic/beat_if.sv
logic/mem_bank.sv
logic/dma_reader.sv
logic/word_fifo.sv
logic/dma_writer.sv
logic/dma_soc_top.sv
testbench/tb_dma_soc.sv
